// ==== build.f ====
+incdir+include
hw/prom_pkg.sv
hw/prog_req_if.sv
hw/dl_header.sv
hw/dl_region_map.sv
hw/prog_writer.sv
hw/eeprom_dump_bridge.sv
hw/prom_loader_top.sv
verif/tb_clk_gen.sv
verif/tb_prom_loader.sv

// ==== hw/dl_header.sv ====
/* download header capture: start table, decrypt settings, joystick mode
   and config write pulses */
`timescale 1ns/1ps
`default_nettype none

`include "prom_cfg.svh"

module dl_header (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   downloading,
    input  wire [24:0]            ioctl_addr,
    input  wire [7:0]             ioctl_data,
    input  wire                   ioctl_wr,
    input  wire                   ioctl_ram,
    output prom_pkg::start_table_t starts,
    output logic                  decrypt,
    output logic                  decrypt_parity,
    output logic [1:0]            joymode,
    output logic                  cfg_we
);

    logic [63:0] start_sr;   // bytes 0..7, shifted in low byte first
    logic        hdr_wr;
    logic        in_start;
    logic        in_header;

    assign hdr_wr    = ioctl_wr && !ioctl_ram;
    assign in_start  = ioctl_addr < 25'(`PROM_START_BYTES);
    assign in_header = !in_start && (ioctl_addr < 25'(`PROM_HEADER_BYTES));
    assign starts    = start_sr;

    // start table
    always_ff @(posedge clk) begin
        if (hdr_wr && in_start) begin
            start_sr <= {ioctl_data, start_sr[63:8]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_we         <= 1'b0;
            decrypt        <= 1'b0;
            decrypt_parity <= 1'b0;
            joymode        <= 2'b00;
        end else begin
            cfg_we <= hdr_wr && in_header;   // echo of every header byte
            if (hdr_wr && in_header) begin
                if (ioctl_addr == 25'(`PROM_CFG_BYTE)) begin
                    {decrypt, decrypt_parity} <= ioctl_data[7:6];
                end
                if (ioctl_addr == 25'(`PROM_JOY_BYTE)) begin
                    joymode <= ioctl_data[1:0];
                end
            end else if (!hdr_wr && !downloading) begin
                decrypt <= 1'b0;   // end of transfer
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/dl_region_map.sv ====
/* payload region classification, word address translation and cpu byte
   decryption */
`timescale 1ns/1ps
`default_nettype none

`include "prom_cfg.svh"

module dl_region_map (
    input  wire [24:0]            ioctl_addr,
    input  wire [7:0]             ioctl_data,
    input  wire                   ioctl_wr,
    input  wire                   ioctl_ram,
    input  prom_pkg::start_table_t starts,
    input  wire                   decrypt,
    input  wire                   decrypt_parity,
    prog_req_if.source            prog_req
);
    import prom_pkg::*;

    logic [24:0] bulk_addr;   // header removed
    logic [15:0] blk;         // 1 KB block index
    logic [15:0] base;
    logic [24:0] rel_addr;
    logic        is_payload;
    logic        do_decrypt;
    logic [7:0]  dec_data;
    region_t     region;
    prog_req_t   req_c;

    assign bulk_addr  = ioctl_addr - 25'(`PROM_HEADER_BYTES);
    assign blk        = {1'b0, bulk_addr[24:10]};
    assign is_payload = ioctl_addr >= 25'(`PROM_HEADER_BYTES);
    assign rel_addr   = bulk_addr - {base[14:0], 10'd0};

    always_comb begin
        region = REG_QSND;
        base   = starts.qsnd;
        if (blk < starts.snd) begin
            region = REG_CPU;
            base   = 16'd0;
        end else if (blk < starts.pcm) begin
            region = REG_SND;
            base   = starts.snd;
        end else if (blk < starts.gfx) begin
            region = REG_PCM;
            base   = starts.pcm;
        end else if (blk < starts.qsnd) begin
            region = REG_GFX;
            base   = starts.gfx;
        end
    end

    // cpu bytes in the upper half with the selected parity are scrambled
    assign do_decrypt = (region == REG_CPU) && decrypt
                        && bulk_addr[`PROM_DECRYPT_BIT] && (bulk_addr[0] ^ decrypt_parity);

    always_comb begin
        dec_data = cipher_inv;
        for (int i = 0; i < 8; i++) begin
            if (ioctl_data[i]) begin
                dec_data = dec_data ^ cipher_mask[i];
            end
        end
    end

    always_comb begin
        req_c.data = do_decrypt ? dec_data : ioctl_data;
        req_c.mask = ioctl_addr[0] ? 2'b01 : 2'b10;   // low active, even byte high
        req_c.prom = (region == REG_QSND);
        case (region)
            REG_CPU: begin
                req_c.addr = rel_addr[22:1] + `PROM_CPU_OFFSET;
                req_c.ba   = 2'd0;
            end
            REG_SND: begin
                req_c.addr = rel_addr[22:1] + `PROM_SND_OFFSET;
                req_c.ba   = 2'd1;
            end
            REG_PCM: begin
                req_c.addr = rel_addr[22:1] + `PROM_PCM_OFFSET;
                req_c.ba   = 2'd1;
            end
            REG_GFX: begin
                req_c.addr = rel_addr[22:1] + `PROM_GFX_OFFSET;
                req_c.ba   = 2'd2;
            end
            default: begin
                req_c.addr = {9'd0, rel_addr[12:0]};   // byte wide PROM
                req_c.ba   = 2'd1;
            end
        endcase
    end

    assign prog_req.req    = req_c;
    assign prog_req.region = region;
    assign prog_req.valid  = ioctl_wr && !ioctl_ram && is_payload;

endmodule

`default_nettype wire

// ==== hw/eeprom_dump_bridge.sv ====
/* byte to 16-bit word packing for EEPROM writes, byte select for readback */
`timescale 1ns/1ps
`default_nettype none

`include "prom_cfg.svh"

module eeprom_dump_bridge (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire [24:0]                 ioctl_addr,
    input  wire [7:0]                  ioctl_data,
    input  wire                        ioctl_wr,
    input  wire                        ioctl_ram,
    input  wire [15:0]                 dump_dout,
    output logic [15:0]                dump_din,
    output logic [`PROM_EEPROM_AW-1:0] dump_addr,
    output logic                       dump_we,
    output logic [7:0]                 ioctl_data2sd
);

    logic ram_wr;

    assign ram_wr        = ioctl_wr && ioctl_ram;
    assign dump_addr     = ioctl_addr[`PROM_EEPROM_AW:1];
    assign ioctl_data2sd = ioctl_addr[0] ? dump_dout[15:8] : dump_dout[7:0];

    // held word, only the addressed half changes
    always_ff @(posedge clk) begin
        if (ram_wr) begin
            if (ioctl_addr[0]) begin
                dump_din[15:8] <= ioctl_data;
            end else begin
                dump_din[7:0] <= ioctl_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dump_we <= 1'b0;
        end else begin
            dump_we <= ram_wr;   // one pulse per byte
        end
    end

endmodule

`default_nettype wire

// ==== hw/prog_req_if.sv ====
/* one mapped write request from the region mapper to the memory writer */
`timescale 1ns/1ps
`default_nettype none

interface prog_req_if;
    import prom_pkg::*;

    prog_req_t req;
    logic      valid;    // one pulse per payload byte
    region_t   region;

    modport source (
        output req,
        output valid,
        output region
    );

    modport sink (
        input req,
        input valid,
        input region
    );

endinterface

`default_nettype wire

// ==== hw/prog_writer.sv ====
/* program memory write register with ready hold, post-download zero-fill
   sweep and busy flag */
`timescale 1ns/1ps
`default_nettype none

`include "prom_cfg.svh"

module prog_writer (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         downloading,
    input  wire         prog_rdy,
    prog_req_if.sink    prog_req,
    output logic [21:0] prog_addr,
    output logic [15:0] prog_data,
    output logic [1:0]  prog_mask,
    output logic [1:0]  prog_ba,
    output logic        prog_we,
    output logic        prom_we,
    output logic        dwnld_busy
);
    import prom_pkg::*;

    logic       clearing;      // zero-fill sweep running
    logic       seen;          // program memory written since last sweep
    logic [7:0] data_r;
    logic       start_clear;
    logic       clear_ack;
    logic       clear_last;

    assign start_clear = !downloading && !clearing && seen;
    assign clear_ack   = clearing && prog_we && prog_rdy;
    assign clear_last  = &prog_addr[`PROM_CLEAR_AW-1:0];
    assign prog_data   = {2{data_r}};   // same byte on both halves

    // address and data path
    always_ff @(posedge clk) begin
        if (prog_req.valid) begin
            prog_addr <= prog_req.req.addr;
            data_r    <= prog_req.req.data;
            prog_mask <= prog_req.req.mask;
            prog_ba   <= prog_req.req.ba;
        end else if (start_clear) begin
            prog_addr <= 22'd0;
            data_r    <= 8'h00;
            prog_mask <= 2'b00;   // both bytes
            prog_ba   <= 2'd0;
        end else if (clear_ack && !clear_last) begin
            prog_addr <= prog_addr + 22'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we    <= 1'b0;
            prom_we    <= 1'b0;
            dwnld_busy <= 1'b0;
            clearing   <= 1'b0;
            seen       <= 1'b0;
        end else if (prog_req.valid) begin
            prog_we    <= !prog_req.req.prom;
            prom_we    <= prog_req.req.prom;
            dwnld_busy <= 1'b1;
            clearing   <= 1'b0;   // new data aborts a sweep
            if (prog_req.region != REG_QSND) begin
                seen <= 1'b1;
            end
        end else if (clearing) begin
            if (clear_ack) begin
                prog_we <= 1'b0;
                if (clear_last) begin
                    clearing   <= 1'b0;
                    dwnld_busy <= 1'b0;
                end
            end else if (!prog_we && !prog_rdy) begin
                prog_we <= 1'b1;   // next word
            end
        end else begin
            if (!downloading || prog_rdy) begin
                prog_we <= 1'b0;
            end
            if (!downloading) begin
                prom_we <= 1'b0;
                if (seen) begin
                    clearing <= 1'b1;
                    prog_we  <= 1'b1;
                    seen     <= 1'b0;
                end else begin
                    dwnld_busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/prom_loader_top.sv ====
/* ROM download router top level: header capture, region mapping, memory
   writer and EEPROM bridge */
`timescale 1ns/1ps
`default_nettype none

`include "prom_cfg.svh"

module prom_loader_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        downloading,
    input  wire [24:0]                 ioctl_addr,
    input  wire [7:0]                  ioctl_data,
    input  wire                        ioctl_wr,
    input  wire                        ioctl_ram,
    output wire [7:0]                  ioctl_data2sd,
    output wire [21:0]                 prog_addr,
    output wire [15:0]                 prog_data,
    output wire [1:0]                  prog_mask,
    output wire [1:0]                  prog_ba,
    output wire                        prog_we,
    output wire                        prom_we,
    input  wire                        prog_rdy,
    output wire                        cfg_we,
    output wire                        dwnld_busy,
    output wire [1:0]                  joymode,
    output wire [15:0]                 dump_din,
    output wire [`PROM_EEPROM_AW-1:0]  dump_addr,
    output wire                        dump_we,
    input  wire [15:0]                 dump_dout
);
    import prom_pkg::*;

    start_table_t starts;
    logic         decrypt;
    logic         decrypt_parity;

    prog_req_if prog_req ();

    dl_header u_header (
        .clk            (clk),
        .rst_n          (rst_n),
        .downloading    (downloading),
        .ioctl_addr     (ioctl_addr),
        .ioctl_data     (ioctl_data),
        .ioctl_wr       (ioctl_wr),
        .ioctl_ram      (ioctl_ram),
        .starts         (starts),
        .decrypt        (decrypt),
        .decrypt_parity (decrypt_parity),
        .joymode        (joymode),
        .cfg_we         (cfg_we)
    );

    dl_region_map u_map (
        .ioctl_addr     (ioctl_addr),
        .ioctl_data     (ioctl_data),
        .ioctl_wr       (ioctl_wr),
        .ioctl_ram      (ioctl_ram),
        .starts         (starts),
        .decrypt        (decrypt),
        .decrypt_parity (decrypt_parity),
        .prog_req       (prog_req.source)
    );

    prog_writer u_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .prog_rdy    (prog_rdy),
        .prog_req    (prog_req.sink),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_ba     (prog_ba),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .dwnld_busy  (dwnld_busy)
    );

    eeprom_dump_bridge u_eeprom (
        .clk           (clk),
        .rst_n         (rst_n),
        .ioctl_addr    (ioctl_addr),
        .ioctl_data    (ioctl_data),
        .ioctl_wr      (ioctl_wr),
        .ioctl_ram     (ioctl_ram),
        .dump_dout     (dump_dout),
        .dump_din      (dump_din),
        .dump_addr     (dump_addr),
        .dump_we       (dump_we),
        .ioctl_data2sd (ioctl_data2sd)
    );

endmodule

`default_nettype wire

// ==== hw/prom_pkg.sv ====
/* region enum, start table and write request structs, byte cipher constants */
`default_nettype none

package prom_pkg;

    typedef enum logic [2:0] {
        REG_CPU  = 3'd0,
        REG_SND  = 3'd1,
        REG_PCM  = 3'd2,
        REG_GFX  = 3'd3,
        REG_QSND = 3'd4   // sound-chip internal PROM
    } region_t;

    // region starts in 1 KB units, snd in the low bits
    typedef struct packed {
        logic [15:0] qsnd;
        logic [15:0] gfx;
        logic [15:0] pcm;
        logic [15:0] snd;
    } start_table_t;

    // one mask per data bit, xor of the set bits then xor with cipher_inv
    localparam logic [7:0] cipher_mask [8] = '{
        8'h04, 8'h21, 8'h01, 8'h50, 8'h40, 8'h06, 8'h08, 8'h88
    };
    localparam logic [7:0] cipher_inv = 8'h88;

    typedef struct packed {
        logic [21:0] addr;   // word address
        logic [7:0]  data;
        logic [1:0]  mask;   // active low byte mask
        logic [1:0]  ba;     // bank
        logic        prom;   // goes to the sound PROM
    } prog_req_t;

endpackage

`default_nettype wire

// ==== include/prom_cfg.svh ====
/* region offsets, header layout, clear width and EEPROM address width */
`ifndef PROM_CFG_SVH
`define PROM_CFG_SVH

// word offsets added to each translated region address
`define PROM_CPU_OFFSET   22'h000000
`define PROM_SND_OFFSET   22'h0a0000
`define PROM_PCM_OFFSET   22'h100000
`define PROM_GFX_OFFSET   22'h000000

`define PROM_HEADER_BYTES 64   // start table plus config header
`define PROM_START_BYTES  8    // four 16-bit region starts
`define PROM_CFG_BYTE     39   // decrypt enable and parity
`define PROM_JOY_BYTE     40   // joystick mode

// cpu address bit that enables decryption, 19 on the board
`define PROM_DECRYPT_BIT  12

`define PROM_CLEAR_AW     8    // 22 on hardware
`define PROM_EEPROM_AW    7

`endif

// ==== verif/tb_clk_gen.sv ====
/* testbench clock and reset generator */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);   // release away from the active edge
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tb_prom_loader.sv ====
/* testbench for the ROM download router: host stimulus, SDRAM and EEPROM
   models, compare tasks and timeout */
`timescale 1ns/1ps
`default_nettype none

`include "prom_cfg.svh"

module tb_prom_loader;
    import prom_pkg::*;

    localparam int N_MAP     = 40;
    localparam int N_DEC     = 24;
    localparam int N_EE      = 32;
    localparam int EE_BYTES  = 2 ** (`PROM_EEPROM_AW + 1);
    localparam int CLEAR_LEN = 2 ** `PROM_CLEAR_AW;
    localparam int LIMIT     = (`PROM_HEADER_BYTES + N_MAP + N_DEC + N_EE + EE_BYTES) * 8
                               + 4 * CLEAR_LEN;

    logic        clk;
    logic        rst_n;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic        ioctl_ram;
    logic [7:0]  ioctl_data2sd;
    logic [21:0] prog_addr;
    logic [15:0] prog_data;
    logic [1:0]  prog_mask;
    logic [1:0]  prog_ba;
    logic        prog_we;
    logic        prom_we;
    logic        prog_rdy = 1'b0;
    logic        cfg_we;
    logic        dwnld_busy;
    logic [1:0]  joymode;
    logic [15:0] dump_din;
    logic [`PROM_EEPROM_AW-1:0] dump_addr;
    logic        dump_we;
    logic [15:0] dump_dout;

    logic [15:0]  eeprom_mem [2 ** `PROM_EEPROM_AW];
    logic [15:0]  exp_mem    [2 ** `PROM_EEPROM_AW];   // expected EEPROM contents
    prog_req_t    wr_log [$];                          // acknowledged memory writes
    start_table_t st;
    int           bound [6];   // region limits in KB starting at cpu
    logic         dec_on;
    logic         dec_par;
    int           rdy_delay;
    int           cycles = 0;
    int           checks;
    int           errors;

    tb_clk_gen clk_gen (.clk(clk), .rst_n(rst_n));

    prom_loader_top dut (.*);

    function automatic logic [7:0] cipher_byte(input logic [7:0] d);
        logic [7:0] r;
        r = cipher_inv;
        for (int i = 0; i < 8; i++) begin
            if (d[i]) begin
                r = r ^ cipher_mask[i];
            end
        end
        return r;
    endfunction

    function automatic logic [24:0] pick_addr(input region_t r);
        return 25'(bound[r] * 1024 + int'($urandom_range((bound[r+1] - bound[r]) * 1024 - 1, 0)));
    endfunction

    // expected write for a payload byte at a bulk address past the header
    function automatic prog_req_t expect_req(input region_t r, input logic [24:0] bulk,
                                             input logic [7:0] d);
        logic [24:0] rel;
        logic [21:0] off;
        prog_req_t   e;
        rel    = bulk - 25'(bound[r] * 1024);
        off    = (r == REG_SND) ? `PROM_SND_OFFSET : (r == REG_PCM) ? `PROM_PCM_OFFSET
               : (r == REG_GFX) ? `PROM_GFX_OFFSET : `PROM_CPU_OFFSET;
        e.addr = (r == REG_QSND) ? {9'd0, rel[12:0]} : rel[22:1] + off;
        e.ba   = (r == REG_CPU) ? 2'd0 : (r == REG_GFX) ? 2'd2 : 2'd1;
        e.mask = bulk[0] ? 2'b01 : 2'b10;
        e.prom = (r == REG_QSND);
        e.data = (r == REG_CPU && dec_on && bulk[`PROM_DECRYPT_BIT] && bulk[0] != dec_par)
                 ? cipher_byte(d) : d;
        return e;
    endfunction

    function automatic prog_req_t observed_req();
        prog_req_t o;
        o.addr = prog_addr;
        o.data = prog_data[7:0];
        o.mask = prog_mask;
        o.ba   = prog_ba;
        o.prom = prom_we;
        return o;
    endfunction

    task automatic check_flag(input string what, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_word(input string what, input logic [15:0] got,
                              input logic [15:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_eeprom_addr(input string what, input logic [`PROM_EEPROM_AW-1:0] got,
                                     input logic [`PROM_EEPROM_AW-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_req(input string what, input prog_req_t got, input prog_req_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t ns: %s got addr %h data %h mask %b ba %0d prom %b",
                     $time, what, got.addr, got.data, got.mask, got.ba, got.prom);
            $display("      expected addr %h data %h mask %b ba %0d prom %b",
                     want.addr, want.data, want.mask, want.ba, want.prom);
        end
    endtask

    // drives one host byte and returns on the falling edge after the strobe
    task automatic send_byte(input logic [24:0] addr, input logic [7:0] d, input logic ram);
        repeat (5) @(negedge clk);
        ioctl_addr = addr;
        ioctl_data = d;
        ioctl_ram  = ram;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
    endtask

    // SDRAM model pulses prog_rdy for one cycle 1 to 3 cycles after prog_we
    always @(negedge clk) begin
        if (!rst_n) begin
            prog_rdy <= 1'b0;
            rdy_delay = 0;
        end else if (prog_rdy) begin
            prog_rdy <= 1'b0;
        end else if (prog_we) begin
            if (rdy_delay == 0) begin
                rdy_delay = $urandom_range(3, 1);
            end
            rdy_delay = rdy_delay - 1;
            if (rdy_delay == 0) begin
                prog_rdy <= 1'b1;
                wr_log.push_back(observed_req());
            end
        end
    end

    // EEPROM model
    assign dump_dout = eeprom_mem[dump_addr];

    always @(posedge clk) begin
        if (dump_we) begin
            eeprom_mem[dump_addr] <= dump_din;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int unsigned seed_init;
        prog_req_t   want;
        logic [24:0] bulk;
        logic [7:0]  d;
        logic [7:0]  cfg_byte;
        logic [7:0]  joy_byte;
        logic [15:0] held;
        int          t_err;
        int          n_dec;

        seed_init   = $urandom(32'hf37c);
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        ioctl_ram   = 1'b0;
        checks      = 0;
        errors      = 0;
        for (int i = 0; i < 2 ** `PROM_EEPROM_AW; i++) begin
            eeprom_mem[i] = 16'(i * 16'h0305) ^ 16'h9c3a;   // differs for every word
            exp_mem[i]    = 16'(i * 16'h0305) ^ 16'h9c3a;
        end
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_flag("dwnld_busy after reset", dwnld_busy, 1'b0);
        check_flag("prog_we after reset", prog_we, 1'b0);
        check_flag("prom_we after reset", prom_we, 1'b0);
        check_flag("cfg_we after reset", cfg_we, 1'b0);
        check_flag("dump_we after reset", dump_we, 1'b0);
        downloading = 1'b1;

        // start table and config header
        t_err    = errors;
        bound[0] = 0;
        for (int i = 1; i < 5; i++) begin
            bound[i] = bound[i-1] + ((i == 1) ? 8 : 1) + $urandom_range(3, 0);
        end
        bound[5] = bound[4] + 8;   // qsnd PROM is 8 KB
        st.snd   = 16'(bound[1]);
        st.pcm   = 16'(bound[2]);
        st.gfx   = 16'(bound[3]);
        st.qsnd  = 16'(bound[4]);
        cfg_byte = 8'($urandom) | 8'h80;   // decrypt on with random parity
        joy_byte = 8'($urandom);
        dec_on   = cfg_byte[7];
        dec_par  = cfg_byte[6];
        for (int i = 0; i < `PROM_HEADER_BYTES; i++) begin
            d = (i < `PROM_START_BYTES) ? st[8*i +: 8] : 8'($urandom);
            if (i == `PROM_CFG_BYTE) begin
                d = cfg_byte;
            end
            if (i == `PROM_JOY_BYTE) begin
                d = joy_byte;
            end
            send_byte(25'(i), d, 1'b0);
            check_flag("cfg_we", cfg_we, i >= `PROM_START_BYTES);
            check_flag("memory write during header", prog_we | prom_we, 1'b0);
        end
        check_byte("joymode", {6'd0, joymode}, {6'd0, joy_byte[1:0]});
        $display("test 1 header capture: %0d errors", errors - t_err);

        // payload across all five regions
        t_err = errors;
        for (int i = 0; i < N_MAP; i++) begin
            region_t r;
            r    = region_t'($urandom_range(4, 0));
            bulk = pick_addr(r);
            d    = 8'($urandom);
            want = expect_req(r, bulk, d);
            send_byte(bulk + 25'(`PROM_HEADER_BYTES), d, 1'b0);
            check_req("mapped write", observed_req(), want);
            check_byte("upper data lane", prog_data[15:8], want.data);
            check_flag("prog_we", prog_we, !want.prom);
        end
        $display("test 2 region mapping: %0d errors", errors - t_err);

        // cpu bytes with half of them above the decrypt bit
        t_err = errors;
        n_dec = 0;
        for (int i = 0; i < N_DEC; i++) begin
            bulk = 25'($urandom_range(8191, 0));
            if (i % 2 == 0) begin
                bulk[`PROM_DECRYPT_BIT] = 1'b1;
            end
            if (bulk[`PROM_DECRYPT_BIT] && bulk[0] != dec_par) begin
                n_dec++;
            end
            d    = 8'($urandom);
            want = expect_req(REG_CPU, bulk, d);
            send_byte(bulk + 25'(`PROM_HEADER_BYTES), d, 1'b0);
            check_req("cpu write", observed_req(), want);
        end
        $display("test 3 decryption: %0d decrypted, %0d errors", n_dec, errors - t_err);

        // zero-fill sweep once downloading falls
        t_err = errors;
        check_flag("dwnld_busy before the sweep", dwnld_busy, 1'b1);
        while (prog_we || prog_rdy) begin
            @(negedge clk);
        end
        wr_log.delete();
        downloading = 1'b0;
        while (dwnld_busy) begin
            @(negedge clk);
        end
        check_flag("sweep complete when dwnld_busy fell", wr_log.size() == CLEAR_LEN, 1'b1);
        repeat (4) @(negedge clk);
        check_flag("no writes after the sweep", wr_log.size() == CLEAR_LEN, 1'b1);
        want = '0;
        for (int i = 0; i < wr_log.size(); i++) begin
            want.addr = 22'(i);
            check_req("clear write", wr_log[i], want);
        end
        $display("test 4 clear sweep: %0d writes, %0d errors", wr_log.size(), errors - t_err);

        // EEPROM packing and readback with word 0 filling the held word first
        t_err = errors;
        held  = 'x;
        for (int i = 0; i < N_EE; i++) begin
            bulk = (i < 2) ? 25'(i) : 25'($urandom_range(EE_BYTES - 1, 0));
            d    = 8'($urandom);
            if (bulk[0]) begin
                held[15:8] = d;
            end else begin
                held[7:0] = d;
            end
            exp_mem[bulk[`PROM_EEPROM_AW:1]] = held;
            send_byte(bulk, d, 1'b1);
            check_flag("dump_we", dump_we, 1'b1);
            check_eeprom_addr("EEPROM word address", dump_addr, bulk[`PROM_EEPROM_AW:1]);
            check_word("packed EEPROM word", dump_din, held);
        end
        for (int a = 0; a < EE_BYTES; a++) begin
            @(negedge clk);
            ioctl_addr = 25'(a);
            @(negedge clk);
            check_byte("readback byte", ioctl_data2sd,
                       (a % 2) ? exp_mem[a / 2][15:8] : exp_mem[a / 2][7:0]);
        end
        $display("test 5 EEPROM path: %0d errors", errors - t_err);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
